/* dv/lcd_vectors.txt */
# cfg <hex>: {two_line, font_5x10, display_on, cursor_on, blink_on, increment, shift}
# command: panel rs rw data(hex) gap(cycles, 0 = random)
cfg 5a
0 1 0 41 3
1 1 0 42 5
2 0 0 80 2
3 1 0 43 0
1 1 0 44 1
1 1 0 45 1
1 1 0 46 1
0 0 1 c0 120
2 1 0 47 0
2 1 0 48 0
3 0 0 0c 110
3 1 0 49 1
3 1 0 4a 1
0 1 1 4b 0
1 1 0 4c 0
2 1 0 4d 0

/* build.f */
source/lcd_pkg.sv
source/lcd_cmd_dispatch.sv
source/lcd_controller.sv
source/lcd_status_collect.sv
source/lcd_array_top.sv
dv/lcd_pin_monitor.sv
dv/lcd_assertions.sv
dv/tb_lcd_array.sv

/* Bender.yml */
package:
  name: lcd_array

sources:
  - source/lcd_pkg.sv
  - source/lcd_cmd_dispatch.sv
  - source/lcd_controller.sv
  - source/lcd_status_collect.sv
  - source/lcd_array_top.sv
  - target: simulation
    files:
      - dv/lcd_pin_monitor.sv
      - dv/lcd_assertions.sv
      - dv/tb_lcd_array.sv

/* dv/tb_lcd_array.sv */
`timescale 1ns/1ps

module tb_lcd_array;
	import lcd_pkg::*;

	localparam int N_PANELS   = 4;
	localparam int CLK_PER_US = 2;
	localparam int CNT_W      = 11;
	localparam int IDX_W      = (N_PANELS > 1) ? $clog2(N_PANELS) : 1;
	localparam int MAX_VEC    = 64;

	logic                clk = 1'b0;
	logic                rst_n;
	lcd_cfg_t            cfg;
	logic                cmd_strobe;
	logic [IDX_W-1:0]    cmd_panel;
	lcd_cmd_t            cmd;
	logic [N_PANELS-1:0] slot_free;
	logic                drop;
	lcd_pins_t           pins [N_PANELS];
	logic [N_PANELS-1:0] ready;
	logic                all_init;
	logic [7:0]          done_count [N_PANELS];

	int       n_vec = 0;
	int       vec_panel [MAX_VEC];
	lcd_cmd_t vec_cmd [MAX_VEC];
	int       vec_gap [MAX_VEC];
	int       cycles = 0;
	int       limit = 0;
	int       asrt_fails [N_PANELS];

	always #10 clk = ~clk;

	lcd_array_top #(
		.N_PANELS  (N_PANELS),
		.CLK_PER_US(CLK_PER_US),
		.CNT_W     (CNT_W)
	) DUT (
		.clk(clk), .rst_n(rst_n), .cfg(cfg), .cmd_strobe(cmd_strobe),
		.cmd_panel(cmd_panel), .cmd(cmd), .slot_free(slot_free), .drop(drop),
		.pins(pins), .ready(ready), .all_init(all_init), .done_count(done_count)
	);

	lcd_pin_monitor #(
		.N_PANELS  (N_PANELS),
		.CLK_PER_US(CLK_PER_US)
	) u_mon (
		.clk(clk), .rst_n(rst_n), .cfg(cfg), .cmd_strobe(cmd_strobe),
		.cmd_panel(cmd_panel), .cmd(cmd), .pins(pins), .slot_free(slot_free),
		.drop(drop), .ready(ready), .all_init(all_init), .done_count(done_count)
	);

	for (genvar p = 0; p < N_PANELS; p++) begin : g_af
		assign asrt_fails[p] = DUT.g_panel[p].u_ctrl.u_asrt.fails;
	end

	// cfg line, then one command per line
	task automatic read_vectors(output bit ok);
		int         fd;
		string      line;
		int         p;
		int         rs;
		int         rw;
		int         gap;
		logic [7:0] d;
		logic [6:0] c;
		ok = 1'b0;
		fd = $fopen("dv/lcd_vectors.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line.getc(0) == 8'h23)
					continue;  // blank or comment
				if ($sscanf(line, "cfg %h", c) == 1) begin
					cfg = c;
				end else if ($sscanf(line, "%d %d %d %h %d", p, rs, rw, d, gap) == 5
					&& n_vec < MAX_VEC) begin
					vec_panel[n_vec] = p;
					vec_cmd[n_vec]   = '{rs: rs[0], rw: rw[0], data: d};
					vec_gap[n_vec]   = gap;
					n_vec++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic send_command(int i);
		int gap;
		gap = (vec_gap[i] == 0) ? int'($urandom_range(1, 30)) : vec_gap[i];
		@(posedge clk);
		#2;
		cmd_strobe = 1'b1;
		cmd_panel  = IDX_W'(vec_panel[i]);
		cmd        = vec_cmd[i];
		@(posedge clk);
		#2;
		cmd_strobe = 1'b0;
		repeat (gap - 1) @(posedge clk);
	endtask

	// run limit, sized once the vectors are known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run exceeded %0d cycles", limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		bit ok;
		int total;
		void'($urandom(60157));
		rst_n      = 1'b0;
		cmd_strobe = 1'b0;
		cmd_panel  = '0;
		cmd        = '0;
		cfg        = '0;
		read_vectors(ok);
		limit = 940 * CLK_PER_US + 60 * CLK_PER_US * n_vec + 200;
		if (!ok) begin
			$display("could not open dv/lcd_vectors.txt");
			$display("TESTS FAILED");
			$finish;
		end else begin
			repeat (10) @(posedge clk);
			#2 rst_n = 1'b1;
			wait (all_init === 1'b1);
			for (int i = 0; i < n_vec; i++) begin
				send_command(i);
			end
			wait (u_mon.settled === 1'b1);
			repeat (5) @(posedge clk);
			u_mon.final_check();
			total = u_mon.errors;
			for (int p = 0; p < N_PANELS; p++) begin
				total += asrt_fails[p];
			end
			$display("errors: %0d total, %0d from monitor, %0d vectors run",
				total, u_mon.errors, n_vec);
			if (total == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

/* dv/lcd_assertions.sv */
`timescale 1ns/1ps

module lcd_assertions #(
	parameter int CLK_PER_US = 2
) (
	input logic                clk,
	input logic                rst_n,
	input lcd_pkg::lcd_state_e state,
	input logic                busy,
	input logic                lcd_enable,
	input lcd_pkg::lcd_pins_t  pins
);
	import lcd_pkg::*;

	localparam int WR_CYC = 50 * CLK_PER_US;  // busy time of one write
	localparam int E_CYC  = 13 * CLK_PER_US;  // e high time of one write

	int fails = 0;

	busy_held_for_write: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) && $past(state) == ST_WRITE |->
			$past(busy, WR_CYC) && !$past(busy, WR_CYC + 1))
		else begin $error("busy not held for exactly one write cycle"); fails++; end

	e_width_in_write: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(pins.e) && state == ST_WRITE |->
			$past(pins.e, E_CYC) && !$past(pins.e, E_CYC + 1))
		else begin $error("e pulse of a write has the wrong width"); fails++; end

	enable_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_enable |=> busy && !$past(busy))
		else begin $error("lcd_enable while busy or not taken"); fails++; end

	bus_stable_in_e: assert property (@(posedge clk) disable iff (!rst_n)
		pins.e && $past(pins.e) |-> $stable({pins.rs, pins.rw, pins.data}))
		else begin $error("bus changed during e high"); fails++; end

endmodule

bind lcd_controller lcd_assertions #(
	.CLK_PER_US(CLK_PER_US)
) u_asrt (
	.clk        (clk),
	.rst_n      (rst_n),
	.state      (state),
	.busy       (busy),
	.lcd_enable (lcd_enable),
	.pins       (pins)
);

/* dv/lcd_pin_monitor.sv */
`timescale 1ns/1ps

module lcd_pin_monitor #(
	parameter int N_PANELS   = 4,
	parameter int CLK_PER_US = 2,
	localparam int IDX_W = (N_PANELS > 1) ? $clog2(N_PANELS) : 1
) (
	input logic                clk,
	input logic                rst_n,
	input lcd_pkg::lcd_cfg_t   cfg,
	input logic                cmd_strobe,
	input logic [IDX_W-1:0]    cmd_panel,
	input lcd_pkg::lcd_cmd_t   cmd,
	input lcd_pkg::lcd_pins_t  pins [N_PANELS],
	input logic [N_PANELS-1:0] slot_free,
	input logic                drop,
	input logic [N_PANELS-1:0] ready,
	input logic                all_init,
	input logic [7:0]          done_count [N_PANELS]
);
	import lcd_pkg::*;

	localparam int INIT_CYC = 940 * CLK_PER_US;  // power-up plus init
	localparam int WR_CYC   = 50 * CLK_PER_US;   // busy time of one write

	logic [9:0]          exp_q [N_PANELS][$];  // {rs, rw, data} still to show up
	logic [N_PANELS-1:0] full_m;               // modelled pending slots
	logic [N_PANELS-1:0] e_q;
	logic                drop_m;
	logic                all_init_q;
	logic                settled;
	int                  init_left;
	int                  wr_left [N_PANELS];
	int                  pulses [N_PANELS];
	int                  sent [N_PANELS];      // commands taken into a slot
	int                  errors = 0;

	// init word i as the panel datasheet orders them
	function automatic logic [9:0] init_word(int i, lcd_cfg_t f);
		case (i)
			0:       return {2'b00, 4'b0011, f.two_line, f.font_5x10, 2'b00};
			1:       return {2'b00, 5'b00001, f.display_on, f.cursor_on, f.blink_on};
			2:       return {2'b00, 8'h01};
			default: return {2'b00, 6'b000001, f.increment, f.shift};
		endcase
	endfunction

	task automatic flag_mismatch(string name, logic [31:0] want, logic [31:0] got);
		errors++;
		$display("CHECK FAILED %s: expected %h, got %h at %0t", name, want, got, $time);
	endtask

	task automatic flag_problem(string what);
		errors++;
		$display("error: %s at %0t", what, $time);
	endtask

	always @(posedge clk or negedge rst_n) begin
		logic [N_PANELS-1:0] busy_m;
		logic [N_PANELS-1:0] issue;
		logic [N_PANELS-1:0] take;
		logic [9:0]          got;
		logic [9:0]          want;
		if (!rst_n) begin
			full_m     = '0;
			e_q        = '0;
			drop_m     = 1'b0;
			all_init_q = 1'b0;
			settled    = 1'b0;
			init_left  = INIT_CYC;
			for (int p = 0; p < N_PANELS; p++) begin
				wr_left[p] = 0;
				pulses[p]  = 0;
				sent[p]    = 0;
				exp_q[p].delete();
				for (int i = 0; i < 4; i++) begin
					exp_q[p].push_back(init_word(i, cfg));
				end
			end
		end else begin
			for (int p = 0; p < N_PANELS; p++) begin
				busy_m[p] = (init_left > 0) || (wr_left[p] > 0);
			end
			issue = full_m & ~busy_m;

			if (drop !== drop_m)
				flag_mismatch("drop", drop_m, drop);
			if (slot_free !== ~full_m)
				flag_mismatch("slot_free", ~full_m, slot_free);
			if (ready !== ~busy_m)
				flag_mismatch("ready", ~busy_m, ready);

			for (int p = 0; p < N_PANELS; p++) begin
				if (pins[p].e && !busy_m[p])
					flag_problem($sformatf("panel %0d drove e while not busy", p));
				if (pins[p].e && !e_q[p]) begin  // rising e, word is latched by panel
					pulses[p]++;
					got = {pins[p].rs, pins[p].rw, pins[p].data};
					if (exp_q[p].size() == 0) begin
						flag_problem($sformatf("panel %0d showed an e pulse with nothing expected", p));
					end else begin
						want = exp_q[p].pop_front();
						if (got[9] !== want[9])
							flag_mismatch($sformatf("pins[%0d].rs", p), want[9], got[9]);
						if (got[8] !== want[8])
							flag_mismatch($sformatf("pins[%0d].rw", p), want[8], got[8]);
						if (got[7:0] !== want[7:0])
							flag_mismatch($sformatf("pins[%0d].data", p), want[7:0], got[7:0]);
					end
				end
				e_q[p] = pins[p].e;
			end

			if (all_init && !all_init_q) begin
				if (init_left > 0)
					flag_problem("all_init rose before every panel finished init");
				if (slot_free !== '1)
					flag_mismatch("slot_free", {N_PANELS{1'b1}}, slot_free);
				for (int p = 0; p < N_PANELS; p++) begin
					if (pulses[p] != 4)
						flag_mismatch($sformatf("init pulses panel %0d", p), 4, pulses[p]);
				end
			end
			if (!all_init && all_init_q)
				flag_problem("all_init fell after it had risen");
			all_init_q = all_init;

			// slot model; a full slot refuses even on its issue edge
			take   = '0;
			drop_m = 1'b0;
			if (cmd_strobe) begin
				if (full_m[cmd_panel]) begin
					drop_m = 1'b1;
				end else begin
					take[cmd_panel] = 1'b1;
					sent[cmd_panel]++;
					exp_q[cmd_panel].push_back({cmd.rs, cmd.rw, cmd.data});
				end
			end
			full_m = (full_m & ~issue) | take;

			for (int p = 0; p < N_PANELS; p++) begin
				if (issue[p])
					wr_left[p] = WR_CYC;
				else if (wr_left[p] > 0)
					wr_left[p]--;
			end
			if (init_left > 0)
				init_left--;

			settled = (full_m == '0) && (init_left == 0) && !drop_m;
			for (int p = 0; p < N_PANELS; p++) begin
				if (wr_left[p] > 0 || exp_q[p].size() != 0)
					settled = 1'b0;
			end
		end
	end

	// done_count lags busy by one cycle, call a few cycles after settling
	task automatic final_check();
		for (int p = 0; p < N_PANELS; p++) begin
			if (done_count[p] !== 8'(sent[p]))
				flag_mismatch($sformatf("done_count[%0d]", p), 8'(sent[p]), done_count[p]);
			if (exp_q[p].size() != 0)
				flag_problem($sformatf("panel %0d still waits for %0d words",
					p, exp_q[p].size()));
		end
		if (!all_init_q)
			flag_problem("all_init never rose");
	endtask

endmodule

/* source/lcd_array_top.sv */
`timescale 1ns/1ps

module lcd_array_top #(
	parameter int N_PANELS   = 4,
	parameter int CLK_PER_US = 2,
	parameter int CNT_W      = 11,
	localparam int IDX_W = (N_PANELS > 1) ? $clog2(N_PANELS) : 1
) (
	input  logic                clk,
	input  logic                rst_n,
	input  lcd_pkg::lcd_cfg_t   cfg,
	input  logic                cmd_strobe,
	input  logic [IDX_W-1:0]    cmd_panel,
	input  lcd_pkg::lcd_cmd_t   cmd,
	output logic [N_PANELS-1:0] slot_free,
	output logic                drop,
	output lcd_pkg::lcd_pins_t  pins [N_PANELS],
	output logic [N_PANELS-1:0] ready,
	output logic                all_init,
	output logic [7:0]          done_count [N_PANELS]
);
	import lcd_pkg::*;

	logic [N_PANELS-1:0] busy;
	logic [N_PANELS-1:0] lcd_enable;
	lcd_cmd_t            lcd_cmd [N_PANELS];

	lcd_cmd_dispatch #(
		.N_PANELS(N_PANELS)
	) u_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_strobe (cmd_strobe),
		.cmd_panel  (cmd_panel),
		.cmd        (cmd),
		.busy       (busy),
		.lcd_enable (lcd_enable),
		.lcd_cmd    (lcd_cmd),
		.slot_free  (slot_free),
		.drop       (drop)
	);

	for (genvar p = 0; p < N_PANELS; p++) begin : g_panel
		lcd_controller #(
			.CLK_PER_US(CLK_PER_US),
			.CNT_W     (CNT_W)
		) u_ctrl (
			.clk        (clk),
			.rst_n      (rst_n),
			.cfg        (cfg),
			.lcd_enable (lcd_enable[p]),
			.lcd_cmd    (lcd_cmd[p]),
			.pins       (pins[p]),
			.busy       (busy[p])
		);
	end

	lcd_status_collect #(
		.N_PANELS(N_PANELS)
	) u_status (
		.clk        (clk),
		.rst_n      (rst_n),
		.busy       (busy),
		.ready      (ready),
		.all_init   (all_init),
		.done_count (done_count)
	);

endmodule

/* source/lcd_status_collect.sv */
`timescale 1ns/1ps

module lcd_status_collect #(
	parameter int N_PANELS = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [N_PANELS-1:0] busy,
	output logic [N_PANELS-1:0] ready,
	output logic                all_init,
	output logic [7:0]          done_count [N_PANELS]
);

	logic [N_PANELS-1:0] busy_q;
	logic [N_PANELS-1:0] init_seen;  // first busy fall seen, init over
	logic [N_PANELS-1:0] fall;

	assign ready = ~busy;
	assign fall  = busy_q & ~busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q    <= '1;  // controllers leave reset busy
			init_seen <= '0;
			all_init  <= 1'b0;
		end else begin
			busy_q    <= busy;
			init_seen <= init_seen | fall;
			// sticky since init_seen never clears
			all_init  <= &(init_seen | fall);
		end
	end

	// the fall that ends init is skipped, every later one is a finished write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int p = 0; p < N_PANELS; p++) begin
				done_count[p] <= '0;
			end
		end else begin
			for (int p = 0; p < N_PANELS; p++) begin
				if (fall[p] && init_seen[p]) begin
					done_count[p] <= done_count[p] + 8'd1;  // wraps
				end
			end
		end
	end

endmodule

/* source/lcd_controller.sv */
`timescale 1ns/1ps

module lcd_controller #(
	parameter int CLK_PER_US = 2,
	parameter int CNT_W      = 11
) (
	input  logic               clk,
	input  logic               rst_n,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               lcd_enable,
	input  lcd_pkg::lcd_cmd_t  lcd_cmd,
	output lcd_pkg::lcd_pins_t pins,
	output logic               busy
);
	import lcd_pkg::*;

	// last count of each timed phase
	localparam logic [CNT_W-1:0] PU_LAST   = CNT_W'(PU_US * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] INIT_LAST = CNT_W'(INIT_US * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] WR_LAST   = CNT_W'(WR_US * CLK_PER_US - 1);
	// write enable window, counted from the accept edge
	localparam logic [CNT_W-1:0] E_RISE = CNT_W'(WR_SETUP_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] E_FALL = CNT_W'((WR_SETUP_US + WR_E_US) * CLK_PER_US);

	lcd_state_e       state;
	lcd_state_e       state_d;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_d;
	lcd_cmd_t         cmd_q;    // command of the running write
	lcd_cmd_t         wr_cmd;
	lcd_pins_t        pins_d;
	logic             accept;

	// true while c lies in the e-high part of the init word at start_us
	function automatic logic in_win(logic [CNT_W-1:0] c, int start_us);
		return (int'(c) >= start_us * CLK_PER_US) &&
			(int'(c) < (start_us + INIT_E_US) * CLK_PER_US);
	endfunction

	// pin word at init count c; data is zero in the gaps
	function automatic lcd_pins_t init_pins(logic [CNT_W-1:0] c, lcd_cfg_t f);
		lcd_pins_t w;
		w = '0;
		if (in_win(c, FSET_US)) begin
			w.e    = 1'b1;
			w.data = {4'b0011, f.two_line, f.font_5x10, 2'b00};
		end else if (in_win(c, DCTL_US)) begin
			w.e    = 1'b1;
			w.data = {5'b00001, f.display_on, f.cursor_on, f.blink_on};
		end else if (in_win(c, CLR_US)) begin
			w.e    = 1'b1;
			w.data = 8'h01;
		end else if (in_win(c, ENTRY_US)) begin
			w.e    = 1'b1;
			w.data = {6'b000001, f.increment, f.shift};
		end
		return w;
	endfunction

	assign accept = (state == ST_IDLE) && lcd_enable;
	assign wr_cmd = accept ? lcd_cmd : cmd_q;

	always_comb begin
		state_d = state;
		cnt_d   = cnt + 1'b1;
		case (state)
			ST_POWERUP: begin
				if (cnt == PU_LAST) begin
					state_d = ST_INIT;
					cnt_d   = '0;
				end
			end
			ST_INIT: begin
				if (cnt == INIT_LAST) begin
					state_d = ST_IDLE;
					cnt_d   = '0;
				end
			end
			ST_IDLE: begin
				cnt_d = '0;
				if (accept) begin
					state_d = ST_WRITE;
				end
			end
			default: begin  // ST_WRITE
				if (cnt == WR_LAST) begin
					state_d = ST_IDLE;
					cnt_d   = '0;
				end
			end
		endcase
	end

	// outputs follow the next state so they line up with state and cnt
	always_comb begin
		pins_d = '0;
		case (state_d)
			ST_INIT: begin
				pins_d = init_pins(cnt_d, cfg);
			end
			ST_WRITE: begin
				pins_d.rs   = wr_cmd.rs;
				pins_d.rw   = wr_cmd.rw;
				pins_d.data = wr_cmd.data;
				pins_d.e    = (cnt_d >= E_RISE) && (cnt_d < E_FALL);
			end
			default: begin
				pins_d = '0;  // idle and power-up keep the bus quiet
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_POWERUP;
			cnt   <= '0;
			pins  <= '0;
			busy  <= 1'b1;
		end else begin
			state <= state_d;
			cnt   <= cnt_d;
			pins  <= pins_d;
			busy  <= (state_d != ST_IDLE);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= lcd_cmd;
		end
	end

endmodule

/* source/lcd_cmd_dispatch.sv */
`timescale 1ns/1ps

module lcd_cmd_dispatch #(
	parameter int N_PANELS = 4,
	localparam int IDX_W = (N_PANELS > 1) ? $clog2(N_PANELS) : 1
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cmd_strobe,
	input  logic [IDX_W-1:0]      cmd_panel,
	input  lcd_pkg::lcd_cmd_t     cmd,
	input  logic [N_PANELS-1:0]   busy,
	output logic [N_PANELS-1:0]   lcd_enable,
	output lcd_pkg::lcd_cmd_t     lcd_cmd [N_PANELS],
	output logic [N_PANELS-1:0]   slot_free,
	output logic                  drop
);
	import lcd_pkg::*;

	lcd_cmd_t            slot [N_PANELS];  // one pending command per panel
	logic [N_PANELS-1:0] full;
	logic [N_PANELS-1:0] hit;              // strobe decoded to a panel
	logic [N_PANELS-1:0] take;             // strobe lands in an empty slot
	logic                in_range;

	assign in_range = (int'(cmd_panel) < N_PANELS);

	always_comb begin
		for (int p = 0; p < N_PANELS; p++) begin
			hit[p] = cmd_strobe && (int'(cmd_panel) == p);
		end
	end

	// a slot being issued this cycle still counts as full, so a
	// strobe to it on the same edge is refused
	assign take = hit & ~full;

	// issue as soon as the panel is idle; the slot empties on that edge
	assign lcd_enable = full & ~busy;
	assign slot_free  = ~full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= '0;
			drop <= 1'b0;
		end else begin
			full <= (full & ~lcd_enable) | take;
			// refused: slot occupied, or no such panel
			drop <= cmd_strobe && ((|(hit & full)) || !in_range);
		end
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < N_PANELS; p++) begin
			if (take[p]) begin
				slot[p] <= cmd;
			end
		end
	end

	assign lcd_cmd = slot;

endmodule

/* source/lcd_pkg.sv */
package lcd_pkg;

	// panel setup bits, msb first in the order they land in the init words
	typedef struct packed {
		logic two_line;   // N bit of function set
		logic font_5x10;  // F bit of function set
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;  // I/D bit of entry mode
		logic shift;      // S bit of entry mode
	} lcd_cfg_t;

	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_cmd_t;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	typedef enum logic [1:0] {
		ST_POWERUP,
		ST_INIT,
		ST_IDLE,
		ST_WRITE
	} lcd_state_e;

	// panel delays in microseconds, scaled by the clock rate in each controller
	localparam int PU_US       = 500;  // power-up wait
	localparam int INIT_US     = 440;  // whole init sequence
	localparam int INIT_E_US   = 10;   // e high at the start of each init word
	localparam int FSET_US     = 0;    // start of function set
	localparam int DCTL_US     = 60;   // start of display control
	localparam int CLR_US      = 120;  // start of clear
	localparam int ENTRY_US    = 330;  // start of entry mode
	localparam int WR_US       = 50;   // one host write cycle
	localparam int WR_SETUP_US = 1;    // rs/rw/data ahead of e
	localparam int WR_E_US     = 13;   // e high time on a write

endpackage
